// File: common/drawcon_defines.svh
`ifndef DRAWCON_DEFINES_SVH
`define DRAWCON_DEFINES_SVH

////////////////////
// display geometry
////////////////////
`define SCREEN_W        1280
`define SCREEN_H        800
`define COORD_X_W       11      // enough for 0..1279
`define COORD_Y_W       10      // enough for 0..799

// colour depth per channel
`define COLOR_W         4

////////////////////
// sprite geometry
////////////////////
`define PLAYER_W        32
`define PLAYER_H        42
`define GHOST_W         32
`define GHOST_H         32
`define NUM_GHOSTS      4
`define SPRITE_ROW_W    6       // row offset inside a sprite
`define SPRITE_COL_W    5       // column offset inside a sprite

// fixed colours packed as {r, g, b}
`define BG_COLOR        12'h124
`define GAME_OVER_COLOR 12'h306

`endif

// File: common/video_pkg.sv
`include "drawcon_defines.svh"

package video_pkg;

    // screen coordinates
    typedef logic [`COORD_X_W-1:0] coord_x_t;
    typedef logic [`COORD_Y_W-1:0] coord_y_t;

    typedef logic [`COLOR_W-1:0] channel_t;

    // one 12-bit colour with r in the top nibble
    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } pixel_pos_t;

    // what leaves the compositor each clock
    typedef struct packed {
        logic valid;
        rgb_t rgb;
    } pixel_out_t;

endpackage

// File: common/sprite_pkg.sv
`include "drawcon_defines.svh"

package sprite_pkg;

    // selects which sprite memory a word belongs to
    typedef enum logic {
        SPR_PLAYER = 1'b0,
        SPR_GHOST  = 1'b1
    } sprite_kind_e;

    ////////////////////
    // sprite word index
    ////////////////////
    typedef struct packed {
        sprite_kind_e              kind;
        logic                      facing;   // 1 = right
        logic [`SPRITE_ROW_W-1:0]  row;
        logic [`SPRITE_COL_W-1:0]  col;
    } sprite_field_t;

    // apb word index seen flat or split into fields
    typedef union packed {
        logic [12:0]   raw;
        sprite_field_t f;
    } sprite_addr_u;

    // top-left corner of an object on screen
    typedef video_pkg::pixel_pos_t object_pos_t;

endpackage

// File: sprite/sprite_mem.sv
`timescale 1ns/1ps

module sprite_mem
    import video_pkg::*;
#(
    parameter int DEPTH_ROWS = 32,
    parameter int ID         = 0
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [11:0] waddr,
    input  rgb_t        wdata,
    input  logic [11:0] raddr,
    output rgb_t        rdata,
    input  logic [1:0]  hit_in,     // {valid, hit} from the fetch stage
    output logic [1:0]  hit_out
);

    // both facings of 64 rows by 32 columns
    rgb_t mem [0:4095];

    ////////////////////
    // write port
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
    end

    ////////////////////
    // read port
    ////////////////////
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

    // keep hit and valid lined up with the colour
    always_ff @(posedge clk)
    begin
        if (reset)
            hit_out <= 2'b00;
        else
            hit_out <= hit_in;
    end

    // the loader must never land a write outside the rows this sprite owns
    a_write_row: assert property (@(posedge clk) disable iff (reset)
        we |-> (waddr[10:5] < DEPTH_ROWS))
        else $error("sprite_mem %0d: write to row %0d", ID, waddr[10:5]);

endmodule

// File: sprite/sprite_fetch.sv
`timescale 1ns/1ps
`include "drawcon_defines.svh"

module sprite_fetch
    import video_pkg::*;
    import sprite_pkg::*;
#(
    parameter int NUM_OBJ = 1,
    parameter int SPR_W   = 32,
    parameter int SPR_H   = 32
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic               pix_valid,
    input  pixel_pos_t         pix_pos,
    input  object_pos_t        obj_pos [NUM_OBJ],
    input  logic [NUM_OBJ-1:0] obj_en,
    input  logic [NUM_OBJ-1:0] facing,
    output logic               hit,
    output logic [11:0]        raddr
);

    coord_x_t           dx [NUM_OBJ];   // column offset into each object
    coord_y_t           dy [NUM_OBJ];   // row offset into each object
    logic [NUM_OBJ-1:0] in_box;
    logic [11:0]        addr_next;

    ////////////////////
    // hit test
    ////////////////////
    always_comb
    begin
        for (int i = 0; i < NUM_OBJ; i++)
        begin
            dx[i] = pix_pos.x - obj_pos[i].x;
            dy[i] = pix_pos.y - obj_pos[i].y;
            // offsets only mean something once the pixel is past the corner
            in_box[i] = obj_en[i] && pix_valid
                        && (pix_pos.x >= obj_pos[i].x) && (dx[i] < SPR_W)
                        && (pix_pos.y >= obj_pos[i].y) && (dy[i] < SPR_H);
        end
    end

    // walk down so the lowest index is the one that sticks
    always_comb
    begin
        addr_next = '0;
        for (int i = NUM_OBJ - 1; i >= 0; i--)
        begin
            if (in_box[i])
                addr_next = {facing[i], dy[i][`SPRITE_ROW_W-1:0], dx[i][`SPRITE_COL_W-1:0]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            hit <= 1'b0;
        else
            hit <= |in_box;
    end

    always_ff @(posedge clk)
    begin
        raddr <= addr_next;     // don't care while hit is low
    end

    a_row_range: assert property (@(posedge clk) disable iff (reset)
        hit |-> (raddr[10:5] < SPR_H))
        else $error("sprite_fetch: row offset %0d past sprite height", raddr[10:5]);

endmodule

// File: logic/facing_select.sv
`timescale 1ns/1ps
`include "drawcon_defines.svh"

module facing_select
    import video_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   left_btn,
    input  logic                   right_btn,
    input  coord_x_t               player_x,
    input  coord_x_t               ghost_x [`NUM_GHOSTS],
    output logic                   player_facing,   // 1 = right
    output logic [`NUM_GHOSTS-1:0] ghost_facing
);

    logic last_dir;     // direction of the last button pressed

    always_ff @(posedge clk)
    begin
        if (reset)
            last_dir <= 1'b1;
        else if (left_btn)
            last_dir <= 1'b0;
        else if (right_btn)
            last_dir <= 1'b1;
    end

    // a held button wins over the remembered direction
    assign player_facing = left_btn ? 1'b0 : (right_btn ? 1'b1 : last_dir);

    // ghosts turn toward the player
    always_comb
    begin
        for (int i = 0; i < `NUM_GHOSTS; i++)
            ghost_facing[i] = (ghost_x[i] < player_x);
    end

endmodule

// File: logic/apb_sprite_loader.sv
`timescale 1ns/1ps
`include "drawcon_defines.svh"

module apb_sprite_loader
    import video_pkg::*;
    import sprite_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [1:0]  mem_we,     // one bit per sprite kind
    output logic [11:0] mem_waddr,
    output rgb_t        mem_wdata
);

    sprite_addr_u word;
    logic         access;       // apb access phase
    logic         row_bad;

    assign word.raw = paddr[14:2];
    assign access   = psel & penable;

    // player sprites are taller than ghosts
    assign row_bad = (word.f.kind == SPR_PLAYER) ? (word.f.row >= `PLAYER_H)
                                                 : (word.f.row >= `GHOST_H);

    assign pready  = access;    // no wait states
    assign pslverr = access & row_bad;
    assign prdata  = 32'h0;     // memories are write only from this side

    ////////////////////
    // memory write
    ////////////////////
    assign mem_we    = (access && pwrite && !row_bad) ? (2'b01 << word.f.kind) : 2'b00;
    assign mem_waddr = {word.f.facing, word.f.row, word.f.col};
    assign mem_wdata = rgb_t'(pwdata[11:0]);

    a_one_kind: assert property (@(posedge clk) disable iff (reset)
        !(mem_we[0] && mem_we[1]))
        else $error("apb_sprite_loader: both sprite memories written at once");

endmodule

// File: logic/pixel_compositor.sv
`timescale 1ns/1ps
`include "drawcon_defines.svh"

module pixel_compositor
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       valid_in,
    input  logic       game_over,
    input  logic       ghost_hit,
    input  logic       player_hit,
    input  rgb_t       ghost_rgb,
    input  rgb_t       player_rgb,
    output pixel_out_t pix_out
);

    rgb_t color;

    ////////////////////
    // priority select
    ////////////////////
    always_comb
    begin
        if (game_over)
            color = rgb_t'(`GAME_OVER_COLOR);
        else if (ghost_hit && (ghost_rgb != '0))    // zero is see-through
            color = ghost_rgb;
        else if (player_hit && (player_rgb != '0))
            color = player_rgb;
        else
            color = rgb_t'(`BG_COLOR);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pix_out.valid <= 1'b0;
        else
            pix_out.valid <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        pix_out.rgb <= color;
    end

endmodule

// File: logic/drawcon_top.sv
`timescale 1ns/1ps
`include "drawcon_defines.svh"

module drawcon_top
    import video_pkg::*;
    import sprite_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // pixel stream
    input  logic                   pix_valid,
    input  pixel_pos_t             pix_pos,
    output pixel_out_t             pix_out,
    // game state, held while pixels are in flight
    input  object_pos_t            player_pos,
    input  object_pos_t            ghost_pos [`NUM_GHOSTS],
    input  logic [`NUM_GHOSTS-1:0] ghost_en,
    input  logic                   left_btn,
    input  logic                   right_btn,
    input  logic                   game_over,
    // apb
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic [1:0]             mem_we;
    logic [11:0]            mem_waddr;
    rgb_t                   mem_wdata;
    coord_x_t               ghost_x [`NUM_GHOSTS];
    object_pos_t            player_obj [1];
    logic                   player_facing;
    logic [`NUM_GHOSTS-1:0] ghost_facing;
    logic                   player_hit, ghost_hit;
    logic [11:0]            player_raddr, ghost_raddr;
    logic                   valid_d1;
    logic [1:0]             player_lane, ghost_lane;    // {valid, hit} after the memory
    rgb_t                   player_rgb, ghost_rgb;

    always_comb
    begin
        for (int i = 0; i < `NUM_GHOSTS; i++)
            ghost_x[i] = ghost_pos[i].x;
    end
    assign player_obj[0] = player_pos;

    apb_sprite_loader loader_i (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .mem_we, .mem_waddr, .mem_wdata
    );

    facing_select facing_i (
        .clk, .reset, .left_btn, .right_btn,
        .player_x(player_pos.x), .ghost_x,
        .player_facing, .ghost_facing
    );

    ////////////////////
    // hit test and address in cycle 1
    ////////////////////
    sprite_fetch #(.NUM_OBJ(1), .SPR_W(`PLAYER_W), .SPR_H(`PLAYER_H)) player_fetch_i (
        .clk, .reset, .pix_valid, .pix_pos,
        .obj_pos(player_obj), .obj_en(1'b1), .facing(player_facing),
        .hit(player_hit), .raddr(player_raddr)
    );

    sprite_fetch #(.NUM_OBJ(`NUM_GHOSTS), .SPR_W(`GHOST_W), .SPR_H(`GHOST_H)) ghost_fetch_i (
        .clk, .reset, .pix_valid, .pix_pos,
        .obj_pos(ghost_pos), .obj_en(ghost_en), .facing(ghost_facing),
        .hit(ghost_hit), .raddr(ghost_raddr)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            valid_d1 <= 1'b0;
        else
            valid_d1 <= pix_valid;
    end

    ////////////////////
    // colour read in cycle 2
    ////////////////////
    sprite_mem #(.DEPTH_ROWS(`PLAYER_H), .ID(0)) player_mem_i (
        .clk, .reset, .we(mem_we[SPR_PLAYER]), .waddr(mem_waddr), .wdata(mem_wdata),
        .raddr(player_raddr), .rdata(player_rgb),
        .hit_in({valid_d1, player_hit}), .hit_out(player_lane)
    );

    sprite_mem #(.DEPTH_ROWS(`GHOST_H), .ID(1)) ghost_mem_i (
        .clk, .reset, .we(mem_we[SPR_GHOST]), .waddr(mem_waddr), .wdata(mem_wdata),
        .raddr(ghost_raddr), .rdata(ghost_rgb),
        .hit_in({valid_d1, ghost_hit}), .hit_out(ghost_lane)
    );

    // both lanes carry the same valid into cycle 3
    pixel_compositor compositor_i (
        .clk, .reset,
        .valid_in(player_lane[1] & ghost_lane[1]),
        .game_over,
        .ghost_hit(ghost_lane[0]), .player_hit(player_lane[0]),
        .ghost_rgb, .player_rgb,
        .pix_out
    );

endmodule

// File: sim/drawcon_tb.sv
`timescale 1ns/1ps
`include "drawcon_defines.svh"

module drawcon_tb
    import video_pkg::*;
    import sprite_pkg::*;
();

    localparam int NUM_BURSTS   = 60;
    localparam int BURST_LEN    = 64;
    localparam int LOAD_WORDS   = 2 * (`PLAYER_H + `GHOST_H) * `PLAYER_W + 24;
    localparam int TOTAL_CYCLES = 2 * LOAD_WORDS + NUM_BURSTS * (BURST_LEN + 4) + 64;
    localparam int TIMEOUT_NS   = TOTAL_CYCLES * 8 + 4000;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   pix_valid;
    pixel_pos_t             pix_pos;
    pixel_out_t             pix_out;
    object_pos_t            player_pos;
    object_pos_t            ghost_pos [`NUM_GHOSTS];
    logic [`NUM_GHOSTS-1:0] ghost_en;
    logic                   left_btn;
    logic                   right_btn;
    logic                   game_over;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;

    rgb_t        player_model [0:4095];
    rgb_t        ghost_model [0:4095];
    logic        last_dir_model;        // 1 = right
    pixel_out_t  exp_q [$];
    int          due_q [$];             // cycle at which each expected pixel shows
    int          cycle = 0;
    int          pix_errors = 0;
    int          apb_errors = 0;
    int          misc_errors = 0;
    logic [31:0] rng = 32'h4903_93f4;

    drawcon_top dut_i (
        .clk, .reset, .pix_valid, .pix_pos, .pix_out,
        .player_pos, .ghost_pos, .ghost_en, .left_btn, .right_btn, .game_over,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
    );

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    ////////////////////
    // random numbers
    ////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_word() % n);
    endfunction

    // zero about one time in four
    function automatic rgb_t random_color();
        logic [31:0] r;
        r = rand_word();
        if (r[1:0] == 2'b00)
            return '0;
        if (r[13:2] == 12'h000)
            return rgb_t'(12'h001);
        return rgb_t'(r[13:2]);
    endfunction

    ////////////////////
    // reference model
    ////////////////////
    function automatic pixel_out_t model_pixel(input pixel_pos_t p);
        pixel_out_t res;
        rgb_t       pc;
        rgb_t       gc;
        logic       ph;
        logic       gh;
        logic       face;
        int         dx;
        int         dy;
        ph = 1'b0;
        gh = 1'b0;
        pc = '0;
        gc = '0;
        face = left_btn ? 1'b0 : (right_btn ? 1'b1 : last_dir_model);  // held button first
        dx = int'(p.x) - int'(player_pos.x);
        dy = int'(p.y) - int'(player_pos.y);
        if (dx >= 0 && dx < `PLAYER_W && dy >= 0 && dy < `PLAYER_H)
        begin
            ph = 1'b1;
            pc = player_model[{face, dy[5:0], dx[4:0]}];
        end
        for (int i = 0; i < `NUM_GHOSTS; i++)
        begin
            dx = int'(p.x) - int'(ghost_pos[i].x);
            dy = int'(p.y) - int'(ghost_pos[i].y);
            if (!gh && ghost_en[i] && dx >= 0 && dx < `GHOST_W && dy >= 0 && dy < `GHOST_H)
            begin
                gh = 1'b1;  // lowest index owns the read port
                face = (ghost_pos[i].x < player_pos.x);
                gc = ghost_model[{face, dy[5:0], dx[4:0]}];
            end
        end
        res.valid = 1'b1;
        if (game_over)
            res.rgb = rgb_t'(`GAME_OVER_COLOR);
        else if (gh && gc != '0)
            res.rgb = gc;
        else if (ph && pc != '0)
            res.rgb = pc;
        else
            res.rgb = rgb_t'(`BG_COLOR);
        return res;
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_pixel(input pixel_out_t got, input pixel_out_t exp);
        if (got !== exp)
        begin
            pix_errors++;
            $display("ERROR pix_out: got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp)
        begin
            pix_errors++;
            $display("ERROR pix_out.valid: got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_apb(input logic got, input logic exp);
        if (got !== exp)
        begin
            apb_errors++;
            $display("ERROR pslverr: got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            apb_errors++;
            $display("ERROR prdata: got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    // output lags the drive by 3 clocks; anything not due must be invalid
    always @(negedge clk)
    begin
        if (due_q.size() > 0 && due_q[0] == cycle)
        begin
            void'(due_q.pop_front());
            check_pixel(pix_out, exp_q.pop_front());
        end
        else
            check_valid(pix_out.valid, 1'b0);
    end

    ////////////////////
    // drivers
    ////////////////////
    task automatic apb_write(input sprite_addr_u a, input rgb_t c, input logic exp_err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = {17'h0, a.raw, 2'b00};
        pwdata = {20'h0, c};
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);
        if (pready !== 1'b1)
        begin
            misc_errors++;
            $display("pready was low during an APB access phase at %0t", $time);
        end
        check_apb(pslverr, exp_err);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        if (!exp_err && a.f.kind == SPR_PLAYER)
            player_model[a.raw[11:0]] = c;
        else if (!exp_err)
            ghost_model[a.raw[11:0]] = c;
    endtask

    // a read returns zero and leaves the memory alone
    task automatic apb_read(input sprite_addr_u a);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = {17'h0, a.raw, 2'b00};
        pwdata = 32'h0000_0fff;
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);
        if (pready !== 1'b1)
        begin
            misc_errors++;
            $display("pready was low during an APB access phase at %0t", $time);
        end
        check_apb(pslverr, 1'b0);
        check_rdata(prdata, 32'h0);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_pixel(input logic v, input pixel_pos_t p);
        pix_valid = v;
        pix_pos = p;
        if (v)
        begin
            exp_q.push_back(model_pixel(p));
            due_q.push_back(cycle + 3);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        repeat (4) send_pixel(1'b0, pix_pos);
    endtask

    // player somewhere on screen with ghosts crowded around it
    task automatic set_scene();
        int          px;
        int          py;
        logic [31:0] r;
        px = 64 + rand_below(1100);
        py = 64 + rand_below(650);
        player_pos.x = coord_x_t'(px);
        player_pos.y = coord_y_t'(py);
        for (int i = 0; i < `NUM_GHOSTS; i++)
        begin
            ghost_pos[i].x = coord_x_t'(px - 24 + rand_below(49));
            ghost_pos[i].y = coord_y_t'(py - 24 + rand_below(49));
        end
        r = rand_word();
        ghost_en = r[3:0];
        left_btn = r[4];
        right_btn = r[5];
        game_over = (r[10:8] == 3'd0);
    endtask

    task automatic run_burst();
        pixel_pos_t p;
        for (int n = 0; n < BURST_LEN; n++)
        begin
            p.x = coord_x_t'(int'(player_pos.x) - 8 + rand_below(64));
            p.y = coord_y_t'(int'(player_pos.y) - 8 + rand_below(64));
            send_pixel(rand_below(8) != 0, p);     // mostly back to back
        end
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the run finished");
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        sprite_addr_u a;
        reset = 1'b1;
        pix_valid = 1'b0;
        pix_pos = '0;
        player_pos = '0;
        for (int i = 0; i < `NUM_GHOSTS; i++)
            ghost_pos[i] = '0;
        ghost_en = '0;
        left_btn = 1'b0;
        right_btn = 1'b0;
        game_over = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        last_dir_model = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        // fill every row of both facings of both sprites
        for (int k = 0; k < 2; k++)
            for (int f = 0; f < 2; f++)
                for (int r = 0; r < (k ? `GHOST_H : `PLAYER_H); r++)
                    for (int c = 0; c < 32; c++)
                    begin
                        a.f.kind = k ? SPR_GHOST : SPR_PLAYER;
                        a.f.facing = f[0];
                        a.f.row = r[5:0];
                        a.f.col = c[4:0];
                        apb_write(a, random_color(), 1'b0);
                    end

        ////////////////////
        // apb error response
        ////////////////////
        for (int n = 0; n < 8; n++)
        begin
            a.f.kind = n[0] ? SPR_GHOST : SPR_PLAYER;
            a.f.facing = n[1];
            a.f.row = n[0] ? 6'(`GHOST_H + rand_below(64 - `GHOST_H))
                           : 6'(`PLAYER_H + rand_below(64 - `PLAYER_H));
            a.f.col = 5'(rand_below(32));
            apb_write(a, rgb_t'(12'hfff), 1'b1);
        end
        a.raw = {SPR_PLAYER, 1'b1, 6'(`PLAYER_H - 1), 5'd31};  // last legal player row
        apb_write(a, rgb_t'(12'habc), 1'b0);
        a.raw = {SPR_GHOST, 1'b0, 6'(`GHOST_H - 1), 5'd0};
        apb_write(a, rgb_t'(12'h5a5), 1'b0);

        // reads at legal addresses
        for (int n = 0; n < 8; n++)
        begin
            a.f.kind = n[0] ? SPR_GHOST : SPR_PLAYER;
            a.f.facing = n[1];
            a.f.row = 6'(rand_below(`GHOST_H));
            a.f.col = 5'(rand_below(32));
            apb_read(a);
        end

        // pixel bursts with the scene and buttons changing in between
        for (int b = 0; b < NUM_BURSTS; b++)
        begin
            set_scene();
            run_burst();
            if (left_btn)
                last_dir_model = 1'b0;
            else if (right_btn)
                last_dir_model = 1'b1;
            drain();
        end

        if (exp_q.size() != 0)
        begin
            misc_errors++;
            $display("%0d expected pixels never came out", exp_q.size());
        end
        $display("errors: pixel %0d, apb %0d, other %0d", pix_errors, apb_errors, misc_errors);
        if (pix_errors + apb_errors + misc_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: all.f
+incdir+common
common/video_pkg.sv
common/sprite_pkg.sv
sprite/sprite_mem.sv
sprite/sprite_fetch.sv
logic/facing_select.sv
logic/apb_sprite_loader.sv
logic/pixel_compositor.sv
logic/drawcon_top.sv
sim/drawcon_tb.sv

// File: Bender.yml
package:
  name: drawcon

sources:
  - include_dirs:
      - common
    files:
      - common/video_pkg.sv
      - common/sprite_pkg.sv
      - sprite/sprite_mem.sv
      - sprite/sprite_fetch.sv
      - logic/facing_select.sv
      - logic/apb_sprite_loader.sv
      - logic/pixel_compositor.sv
      - logic/drawcon_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/drawcon_tb.sv
